//--- Makefile
VERILATOR ?= verilator
TOP       ?= arrayMachineTb
FILELIST  ?= tb.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb.f
verilog/arrayMachinePkg.sv
verilog/programStore.sv
verilog/stepTimer.sv
verilog/arrayAllocator.sv
verilog/dataMemory.sv
verilog/sequencer.sv
verilog/arrayMachine.sv
verif/arrayMachineChk.sv
verif/arrayMachineTb.sv

//--- verif/arrayMachineChk.sv
// Protocol checks on the array machine status outputs, bound to the top.
// Failing assertions are also counted in assertFails for the testbench.
`timescale 1ns/1ps

module arrayMachineChk
  import arrayMachinePkg::*;
(
  input logic run,
  input logic rstN,
  input logic start,
  input logic finished,
  input logic fault,
  input logic outValid
);

  int assertFails = 0;

  // No emission once the machine has been stopped for a cycle
  quietWhenDone: assert property (@(posedge run) disable iff (!rstN)
    finished && $past(finished) |-> !outValid)
  else
  begin
    assertFails++;
    $error("outValid high while finished");
  end

  holdUntilStart: assert property (@(posedge run) disable iff (!rstN)
    finished && !start |=> finished)
  else
  begin
    assertFails++;
    $error("finished dropped without start");
  end

  faultNeedsFinished: assert property (@(posedge run) disable iff (!rstN)
    fault |-> finished)
  else
  begin
    assertFails++;
    $error("fault high without finished");
  end

endmodule

bind arrayMachine arrayMachineChk i_arrayMachineChk (
  .run     (run),
  .rstN    (rstN),
  .start   (start),
  .finished(finished),
  .fault   (fault),
  .outValid(outValid)
);

//--- verif/arrayMachineTb.sv
// Self-checking testbench for the array machine, stimulus from a fixed seed.
// Generated programs only read array elements and locals they have written,
// since the data memories are not cleared between runs.
`timescale 1ns/1ps

module arrayMachineTb
  import arrayMachinePkg::*;
();

  localparam int ClkPeriod    = 4;
  localparam int ResetCycles  = 10;
  localparam int SettleCycles = 4;                     // Checked after finished
  localparam int NRandom      = 24;
  localparam int NRuns        = NRandom + 6;
  localparam int CyclesPerRun = MaxSteps * 3 + NProg + 12; // Run, load and settle
  localparam int WatchdogNs   = (ResetCycles + NRuns * CyclesPerRun) * ClkPeriod;

  logic                 run;
  logic                 rstN;
  logic                 loadValid;
  logic [PcWidth-1:0]   loadAddr;
  instr_t               loadInstr;
  logic                 start;
  logic                 finished;
  logic                 fault;
  logic                 outValid;
  outWord_t             outWord;

  instr_t               prog [NProg];
  int                   progLen;
  string                testName;
  logic [ElemWidth-1:0] expData [$];                   // Model output words
  logic                 expFault;
  logic [ElemWidth-1:0] gotData [$];                   // DUT output words

  arrayMachine i_arrayMachine (
    .run      (run),
    .rstN     (rstN),
    .loadValid(loadValid),
    .loadAddr (loadAddr),
    .loadInstr(loadInstr),
    .start    (start),
    .finished (finished),
    .fault    (fault),
    .outValid (outValid),
    .outWord  (outWord)
  );

  always #(ClkPeriod / 2) run = ~run;

  // --------------------------------------------------------------------------
  // Checking and program building
  // --------------------------------------------------------------------------
  task automatic compare(string what, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s %s expected %0d actual %0d", testName, what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch in %s", testName);
    end
  endtask

  task automatic addInstr(opcode_t op, int loc, int off, int imm);
    prog[progLen].opcode = op;
    prog[progLen].loc    = LocalIdxWidth'(loc);
    prog[progLen].off    = OffWidth'(off);
    prog[progLen].imm    = ElemWidth'(imm);
    progLen++;
  endtask

  task automatic makeFixedProgram();
    progLen = 0;
    addInstr(opArray, 0, 0, 0);
    addInstr(opArray, 1, 0, 0);
    addInstr(opStoreImm, 0, 0, 11);
    addInstr(opStoreImm, 0, 1, 22);
    addInstr(opStoreImm, 1, 0, 33);
    addInstr(opLoadLocal, 0, 1, 5);                    // local 5 gets 22
    addInstr(opOutHeap, 0, 0, 0);
    addInstr(opOutLocal, 5, 0, 0);
    addInstr(opOutHeap, 1, 0, 0);
    addInstr(opHalt, 0, 0, 0);
  endtask

  task automatic makeRandomProgram();
    bit written [3][NArea];
    bit localSet [NLocal];
    int nArr;
    int kind;
    int a;
    int o;
    int d;
    written  = '{default: '0};
    localSet = '{default: '0};
    progLen  = 0;
    nArr     = 1 + $urandom_range(2);
    for (int i = 0; i < nArr; i++)
    begin
      addInstr(opArray, i, 0, 0);
      localSet[i] = 1'b1;
    end
    repeat (6 + $urandom_range(6))
    begin
      kind = $urandom_range(3);
      a    = $urandom_range(nArr - 1);
      o    = $urandom_range(NArea - 1);
      if (kind == 0 || ((kind == 1 || kind == 2) && !written[a][o]))
      begin
        addInstr(opStoreImm, a, o, $urandom_range(4095));
        written[a][o] = 1'b1;
      end
      if (kind == 1)
      begin
        d = 8 + $urandom_range(7);                     // Clear of array holders
        addInstr(opLoadLocal, a, o, d);
        localSet[d] = 1'b1;
      end
      else if (kind == 2)
        addInstr(opOutHeap, a, o, 0);
      else if (kind == 3)
      begin
        d = $urandom_range(NLocal - 1);
        addInstr(opOutLocal, localSet[d] ? d : a, 0, 0);
      end
    end
    addInstr(opHalt, 0, 0, 0);
  endtask

  // --------------------------------------------------------------------------
  // Reference model of the instruction set
  // --------------------------------------------------------------------------
  task automatic runModel();
    logic [ElemWidth-1:0] heap [NArrays][NArea];
    logic [ElemWidth-1:0] locals [NLocal];
    int                   freed [$];                   // Last in, first out
    int                   fresh;
    int                   steps;
    int                   pc;
    int                   arr;
    bit                   running;
    instr_t               ins;
    expData.delete();
    expFault = 1'b0;
    fresh    = 0;
    steps    = 0;
    pc       = 0;
    running  = 1'b1;
    while (running)
    begin
      ins = prog[pc];
      arr = int'(locals[ins.loc][ArrayIdxWidth-1:0]);
      if (ins.opcode == opHalt)
        running = 1'b0;
      else if (steps == MaxSteps)
      begin
        running  = 1'b0;
        expFault = 1'b1;
      end
      else
      begin
        steps++;
        case (ins.opcode)
          opArray:
          begin
            if (freed.size() > 0)
              locals[ins.loc] = ElemWidth'(freed.pop_back());
            else if (fresh < NArrays)
            begin
              locals[ins.loc] = ElemWidth'(fresh);
              fresh++;
            end
            else
            begin
              running  = 1'b0;                         // Allocator exhausted
              expFault = 1'b1;
            end
          end
          opFree:      if (freed.size() < NArrays) freed.push_back(arr);
          opStoreImm:  heap[arr][ins.off] = ins.imm;
          opLoadLocal: locals[ins.imm[LocalIdxWidth-1:0]] = heap[arr][ins.off];
          opOutHeap:   expData.push_back(heap[arr][ins.off]);
          opOutLocal:  expData.push_back(locals[ins.loc]);
          default:     running = 1'b0;
        endcase
        if (running)
        begin
          if (pc == NProg - 1)
            running = 1'b0;                            // Past the last word
          else
            pc++;
        end
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // DUT driving
  // --------------------------------------------------------------------------
  task automatic loadProgram();
    for (int i = 0; i < progLen; i++)
    begin
      @(negedge run);
      loadValid = 1'b1;
      loadAddr  = PcWidth'(i);
      loadInstr = prog[i];
    end
    @(negedge run);
    loadValid = 1'b0;
  endtask

  // poke writes a halt to word 0 while running, which must be dropped
  task automatic runProgram(string name, bit poke);
    int nOut;
    bit done;
    testName = name;
    runModel();
    gotData.delete();
    nOut = 0;
    done = 1'b0;
    @(negedge run);
    start = 1'b1;
    @(negedge run);
    start            = 1'b0;
    loadValid        = poke;
    loadAddr         = '0;
    loadInstr        = '0;
    loadInstr.opcode = opHalt;
    while (!done)
    begin
      if (outValid)
      begin
        if (nOut < expData.size())
        begin
          compare("output data", 32'(expData[nOut]), 32'(outWord.data));
          compare("output seq", nOut, 32'(outWord.seq));
        end
        else
          compare("output count", expData.size(), nOut + 1);
        gotData.push_back(outWord.data);
        nOut++;
      end
      done = finished;
      if (!done)
      begin
        @(negedge run);
        loadValid = 1'b0;
      end
    end
    compare("output count", expData.size(), nOut);
    compare("fault", 32'(expFault), 32'(fault));
    repeat (SettleCycles)
    begin
      @(negedge run);
      compare("finished held", 1, 32'(finished));
      compare("late output", 0, 32'(outValid));
    end
  endtask

  task automatic checkFixedWords();
    compare("word count", 3, gotData.size());
    compare("word 0", 11, 32'(gotData[0]));
    compare("word 1", 22, 32'(gotData[1]));
    compare("word 2", 33, 32'(gotData[2]));
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    run       = 1'b0;
    rstN      = 1'b0;
    loadValid = 1'b0;
    loadAddr  = '0;
    loadInstr = '0;
    start     = 1'b0;
    progLen   = 0;
    void'($urandom(32'h5c07_0a68));
    repeat (ResetCycles) @(negedge run);
    testName = "reset";
    compare("outValid", 0, 32'(outValid));
    compare("finished", 0, 32'(finished));
    compare("fault", 0, 32'(fault));
    rstN = 1'b1;

    makeFixedProgram();
    loadProgram();
    runProgram("fixedProgram", 1'b0);
    checkFixedWords();

    for (int i = 0; i < NRandom; i++)
    begin
      makeRandomProgram();
      loadProgram();
      runProgram($sformatf("randomProgram%0d", i), 1'b0);
    end

    // Arrays 0 and 2 freed in that order come back as 2 then 0
    progLen = 0;
    for (int i = 0; i < 3; i++)
    begin
      addInstr(opArray, i, 0, 0);
      addInstr(opStoreImm, i, 0, 100 + i);
    end
    addInstr(opFree, 0, 0, 0);
    addInstr(opFree, 2, 0, 0);
    addInstr(opArray, 4, 0, 0);
    addInstr(opArray, 5, 0, 0);
    addInstr(opArray, 6, 0, 0);
    addInstr(opStoreImm, 4, 1, 200);
    addInstr(opOutHeap, 4, 0, 0);
    addInstr(opOutHeap, 5, 0, 0);
    addInstr(opOutLocal, 4, 0, 0);
    addInstr(opOutLocal, 5, 0, 0);
    addInstr(opOutLocal, 6, 0, 0);
    addInstr(opOutHeap, 2, 1, 0);                      // Old holder aliases array 2
    addInstr(opHalt, 0, 0, 0);
    loadProgram();
    runProgram("freeReuse", 1'b0);
    compare("first reused", 2, 32'(gotData[2]));
    compare("second reused", 0, 32'(gotData[3]));

    progLen = 0;
    for (int i = 0; i < NArrays; i++)
      addInstr(opArray, i, 0, 0);
    addInstr(opOutLocal, 3, 0, 0);
    addInstr(opArray, 0, 0, 0);                        // One slot too many
    addInstr(opOutLocal, 0, 0, 0);
    addInstr(opHalt, 0, 0, 0);
    loadProgram();
    runProgram("allocExhaust", 1'b0);
    compare("fault set", 1, 32'(fault));

    // Store is shorter than the step limit, so running off the end stops first
    progLen = 0;
    addInstr(opArray, 0, 0, 0);
    for (int i = 1; i < NProg; i++)
    begin
      if (i % 2 == 1)
        addInstr(opStoreImm, 0, (i / 2) % NArea, i * 5);
      else
        addInstr(opOutHeap, 0, ((i - 1) / 2) % NArea, 0);
    end
    loadProgram();
    runProgram("noHaltRunOff", 1'b0);

    makeFixedProgram();
    loadProgram();
    runProgram("reloadRun", 1'b1);
    checkFixedWords();
    runProgram("restartRun", 1'b0);
    checkFixedWords();

    testName = "assertions";
    compare("assertion failures", 0, i_arrayMachine.i_arrayMachineChk.assertFails);
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial
  begin
    #(WatchdogNs);
    $display("Watchdog expired, the test sequence did not complete in time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "Watchdog timeout");
  end

endmodule

//--- verilog/arrayAllocator.sv
// Array number allocator. Freed numbers are reused last in, first out,
// before any fresh number. Freeing a number twice is not detected.
// allocIdx and allocFail are combinational and valid in every cycle.
`timescale 1ns/1ps

module arrayAllocator
  import arrayMachinePkg::*;
(
  input  logic                     run,
  input  logic                     rstN,
  input  logic                     clear,
  input  logic                     allocReq,
  input  logic                     freeReq,
  input  logic [ArrayIdxWidth-1:0] freeIdx,
  output logic [ArrayIdxWidth-1:0] allocIdx,
  output logic                     allocFail
);

  logic [ArrayIdxWidth-1:0] stack [NArrays];           // Freed arrays
  logic [ArrayIdxWidth:0]   top;                       // Entries on the stack
  logic [ArrayIdxWidth:0]   fresh;                     // Next never used number
  logic                     stackEmpty;
  logic                     canPush;
  logic                     canPop;

  assign stackEmpty = top == '0;
  assign allocIdx   = stackEmpty ? fresh[ArrayIdxWidth-1:0]
                                 : stack[ArrayIdxWidth'(top - 1'b1)];
  assign allocFail  = stackEmpty && fresh == (ArrayIdxWidth + 1)'(NArrays);
  assign canPop     = allocReq && !allocFail && !stackEmpty;
  assign canPush    = freeReq && !clear && top != (ArrayIdxWidth + 1)'(NArrays);

  always_ff @(posedge run or negedge rstN)
  begin
    if (!rstN)
    begin
      top   <= '0;
      fresh <= '0;
    end
    else if (clear)
    begin
      top   <= '0;
      fresh <= '0;
    end
    else if (allocReq && !allocFail)
    begin
      if (canPop)
      begin
        top <= top - 1'b1;                             // Reuse newest freed
      end
      else
      begin
        fresh <= fresh + 1'b1;
      end
    end
    else if (canPush)
    begin
      top <= top + 1'b1;
    end
  end

  always_ff @(posedge run)
  begin
    if (canPush)
    begin
      stack[top[ArrayIdxWidth-1:0]] <= freeIdx;
    end
  end

endmodule

//--- verilog/arrayMachine.sv
// Array machine top level. Load the program while idle or done, then
// pulse start. outValid has no back-pressure and must always be taken.
`timescale 1ns/1ps

module arrayMachine
  import arrayMachinePkg::*;
(
  input  logic               run,
  input  logic               rstN,
  input  logic               loadValid,
  input  logic [PcWidth-1:0] loadAddr,
  input  instr_t             loadInstr,
  input  logic               start,
  output logic               finished,
  output logic               fault,
  output logic               outValid,
  output outWord_t           outWord
);

  logic [PcWidth-1:0]       pc;
  instr_t                   instr;
  logic                     busy;
  logic                     storeWe;
  logic                     clearAll;
  logic                     stepTick;
  logic                     limitHit;
  logic                     allocReq;
  logic                     freeReq;
  logic [ArrayIdxWidth-1:0] freeIdx;
  logic [ArrayIdxWidth-1:0] allocIdx;
  logic                     allocFail;
  logic                     heapWe;
  logic [ArrayIdxWidth-1:0] heapIdx;
  logic [OffWidth-1:0]      heapOff;
  logic [ElemWidth-1:0]     heapWData;
  logic [ElemWidth-1:0]     heapRData;
  logic                     localWe;
  logic [LocalIdxWidth-1:0] localAddr;
  logic [ElemWidth-1:0]     localWData;
  logic [ElemWidth-1:0]     localRData;

  assign storeWe = loadValid && !busy;                 // Loads while running dropped

  programStore i_programStore (
    .run      (run),
    .loadValid(storeWe),
    .loadAddr (loadAddr),
    .loadInstr(loadInstr),
    .pc       (pc),
    .instr    (instr)
  );

  sequencer i_sequencer (
    .run       (run),
    .rstN      (rstN),
    .start     (start),
    .limitHit  (limitHit),
    .instr     (instr),
    .pc        (pc),
    .allocReq  (allocReq),
    .freeReq   (freeReq),
    .freeIdx   (freeIdx),
    .allocIdx  (allocIdx),
    .allocFail (allocFail),
    .heapWe    (heapWe),
    .heapIdx   (heapIdx),
    .heapOff   (heapOff),
    .heapWData (heapWData),
    .heapRData (heapRData),
    .localWe   (localWe),
    .localAddr (localAddr),
    .localWData(localWData),
    .localRData(localRData),
    .stepTick  (stepTick),
    .clearAll  (clearAll),
    .busy      (busy),
    .finished  (finished),
    .fault     (fault),
    .outValid  (outValid),
    .outWord   (outWord)
  );

  stepTimer i_stepTimer (
    .run     (run),
    .rstN    (rstN),
    .clear   (clearAll),
    .stepTick(stepTick),
    .limitHit(limitHit)
  );

  arrayAllocator i_arrayAllocator (
    .run      (run),
    .rstN     (rstN),
    .clear    (clearAll),
    .allocReq (allocReq),
    .freeReq  (freeReq),
    .freeIdx  (freeIdx),
    .allocIdx (allocIdx),
    .allocFail(allocFail)
  );

  dataMemory i_dataMemory (
    .run       (run),
    .heapWe    (heapWe),
    .heapIdx   (heapIdx),
    .heapOff   (heapOff),
    .heapWData (heapWData),
    .heapRData (heapRData),
    .localWe   (localWe),
    .localAddr (localAddr),
    .localWData(localWData),
    .localRData(localRData)
  );

endmodule

//--- verilog/arrayMachinePkg.sv
// Shared sizes, opcodes and records for the array machine.
// Array numbers live in local words, zero extended to ElemWidth.
// Offsets at or above NArea are not stored and read back as zero.

package arrayMachinePkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int ElemWidth = 12;                       // Data word width
  localparam int NArea     = 10;                       // Words per array
  localparam int NArrays   = 16;                       // Array slots
  localparam int NLocal    = 16;                       // Local words
  localparam int NProg     = 32;                       // Program words
  localparam int MaxSteps  = 64;                       // Step limit
  localparam int SeqWidth  = 16;                       // Emission counter width

  localparam int ArrayIdxWidth = $clog2(NArrays);
  localparam int LocalIdxWidth = $clog2(NLocal);
  localparam int PcWidth       = $clog2(NProg);
  localparam int OffWidth      = $clog2(NArea);        // Element offset field
  localparam int StepWidth     = $clog2(MaxSteps + 1); // Counts 0 to MaxSteps
  localparam int HeapWords     = NArrays * NArea;
  localparam int HeapAddrWidth = $clog2(HeapWords);

  // --------------------------------------------------------------------------
  // Opcodes and FSM states
  // --------------------------------------------------------------------------
  // Operand use per opcode:
  //   opArray     local[loc] = new array number
  //   opFree      release array local[loc]
  //   opStoreImm  array local[loc], element off = imm
  //   opLoadLocal local[imm] = element off of array local[loc]
  //   opOutHeap   emit element off of array local[loc]
  //   opOutLocal  emit local[loc]
  //   opHalt      stop, no fault
  typedef enum logic [2:0] {
    opArray,
    opFree,
    opStoreImm,
    opLoadLocal,
    opOutHeap,
    opOutLocal,
    opHalt
  } opcode_t;

  typedef enum logic [2:0] {
    sIdle,                                             // After reset
    sFetch,                                            // Instruction valid, local read issued
    sExec,
    sWrite,                                            // Local write back or emit
    sDone                                              // Halted or faulted
  } seqState_t;

  // --------------------------------------------------------------------------
  // Records
  // --------------------------------------------------------------------------
  typedef struct packed {
    opcode_t                  opcode;
    logic [LocalIdxWidth-1:0] loc;                     // Array holder or source local
    logic [OffWidth-1:0]      off;                     // Element offset
    logic [ElemWidth-1:0]     imm;                     // Immediate or destination local
  } instr_t;

  typedef struct packed {
    logic [ElemWidth-1:0] data;
    logic [SeqWidth-1:0]  seq;                         // Emission count since start
  } outWord_t;

endpackage

//--- verilog/dataMemory.sv
// Heap and local word stores, both with one write and one registered read.
// Heap element address is array * NArea + offset. Offsets at or above
// NArea are dropped on write and read back as zero.
// Contents are not cleared on start.
`timescale 1ns/1ps

module dataMemory
  import arrayMachinePkg::*;
(
  input  logic                     run,
  input  logic                     heapWe,
  input  logic [ArrayIdxWidth-1:0] heapIdx,
  input  logic [OffWidth-1:0]      heapOff,
  input  logic [ElemWidth-1:0]     heapWData,
  output logic [ElemWidth-1:0]     heapRData,
  input  logic                     localWe,
  input  logic [LocalIdxWidth-1:0] localAddr,
  input  logic [ElemWidth-1:0]     localWData,
  output logic [ElemWidth-1:0]     localRData
);

  logic [ElemWidth-1:0]     heapMem  [HeapWords];
  logic [ElemWidth-1:0]     localMem [NLocal];
  logic [HeapAddrWidth-1:0] heapAddr;
  logic                     heapInRange;

  // --------------------------------------------------------------------------
  // Heap
  // --------------------------------------------------------------------------
  assign heapAddr    = HeapAddrWidth'(heapIdx) * HeapAddrWidth'(NArea)
                     + HeapAddrWidth'(heapOff);
  assign heapInRange = heapOff < OffWidth'(NArea);

  always_ff @(posedge run)
  begin
    if (heapWe && heapInRange)
    begin
      heapMem[heapAddr] <= heapWData;
    end
  end

  always_ff @(posedge run)
  begin
    heapRData <= heapInRange ? heapMem[heapAddr] : '0;
  end

  // --------------------------------------------------------------------------
  // Local words
  // --------------------------------------------------------------------------
  always_ff @(posedge run)
  begin
    if (localWe)
    begin
      localMem[localAddr] <= localWData;
    end
  end

  always_ff @(posedge run)
  begin
    localRData <= localMem[localAddr];                 // Old data on same address write
  end

endmodule

//--- verilog/programStore.sv
// Instruction memory with one write port for loading and a registered read.
// Words never loaded read as undefined, so a program must end in opHalt
// or fill the whole store.
`timescale 1ns/1ps

module programStore
  import arrayMachinePkg::*;
(
  input  logic               run,
  input  logic               loadValid,
  input  logic [PcWidth-1:0] loadAddr,
  input  instr_t             loadInstr,
  input  logic [PcWidth-1:0] pc,
  output instr_t             instr
);

  instr_t mem [NProg];

  always_ff @(posedge run)
  begin
    if (loadValid)
    begin
      mem[loadAddr] <= loadInstr;
    end
  end

  // Fetch stage, instr follows pc by one cycle
  always_ff @(posedge run)
  begin
    instr <= mem[pc];
  end

endmodule

//--- verilog/sequencer.sv
// Instruction FSM. Each instruction takes sFetch and sExec, and the
// memory reading ones add sWrite. start is taken only when idle or done.
// opHalt stops cleanly even when the step limit has been reached.
`timescale 1ns/1ps

module sequencer
  import arrayMachinePkg::*;
(
  input  logic                     run,
  input  logic                     rstN,
  input  logic                     start,
  input  logic                     limitHit,
  input  instr_t                   instr,
  output logic [PcWidth-1:0]       pc,
  output logic                     allocReq,
  output logic                     freeReq,
  output logic [ArrayIdxWidth-1:0] freeIdx,
  input  logic [ArrayIdxWidth-1:0] allocIdx,
  input  logic                     allocFail,
  output logic                     heapWe,
  output logic [ArrayIdxWidth-1:0] heapIdx,
  output logic [OffWidth-1:0]      heapOff,
  output logic [ElemWidth-1:0]     heapWData,
  input  logic [ElemWidth-1:0]     heapRData,
  output logic                     localWe,
  output logic [LocalIdxWidth-1:0] localAddr,
  output logic [ElemWidth-1:0]     localWData,
  input  logic [ElemWidth-1:0]     localRData,
  output logic                     stepTick,
  output logic                     clearAll,
  output logic                     busy,
  output logic                     finished,
  output logic                     fault,
  output logic                     outValid,
  output outWord_t                 outWord
);

  seqState_t             state;
  seqState_t             stateNext;
  logic [PcWidth-1:0]    pcQ;
  logic [SeqWidth-1:0]   seqCount;
  logic                  advance;                      // Instruction retires
  logic                  emit;
  logic                  stop;
  logic                  stopFault;
  logic [ElemWidth-1:0]  emitData;

  assign busy     = !(state == sIdle || state == sDone);
  assign clearAll = start && !busy;

  // --------------------------------------------------------------------------
  // Next state and datapath controls
  // --------------------------------------------------------------------------
  // pc is the next program counter, so instr is valid throughout sFetch
  always_comb
  begin
    stateNext  = state;
    pc         = pcQ;
    allocReq   = 1'b0;
    freeReq    = 1'b0;
    heapWe     = 1'b0;
    localWe    = 1'b0;
    stepTick   = 1'b0;
    advance    = 1'b0;
    emit       = 1'b0;
    stop       = 1'b0;
    stopFault  = 1'b0;
    localAddr  = instr.loc;                            // Array holder read in sFetch
    localWData = ElemWidth'(allocIdx);
    heapIdx    = localRData[ArrayIdxWidth-1:0];
    heapOff    = instr.off;
    heapWData  = instr.imm;
    freeIdx    = localRData[ArrayIdxWidth-1:0];
    emitData   = heapRData;
    case (state)
      sIdle, sDone:
      begin
        if (start)
        begin
          stateNext = sFetch;
          pc        = '0;
        end
      end
      sFetch:
      begin
        if (instr.opcode == opHalt)
        begin
          stop = 1'b1;
        end
        else if (limitHit)
        begin
          stop      = 1'b1;                            // Runaway program
          stopFault = 1'b1;
        end
        else
        begin
          stepTick  = 1'b1;
          stateNext = sExec;
        end
      end
      sExec:
      begin
        case (instr.opcode)
          opArray:
          begin
            allocReq = 1'b1;
            if (allocFail)
            begin
              stop      = 1'b1;
              stopFault = 1'b1;
            end
            else
            begin
              localWe = 1'b1;
              advance = 1'b1;
            end
          end
          opFree:
          begin
            freeReq = 1'b1;
            advance = 1'b1;
          end
          opStoreImm:
          begin
            heapWe  = 1'b1;
            advance = 1'b1;
          end
          opLoadLocal, opOutHeap, opOutLocal:
          begin
            stateNext = sWrite;                        // Heap read in flight
          end
          default:
          begin
            stop = 1'b1;                               // Unknown code halts
          end
        endcase
      end
      sWrite:
      begin
        advance = 1'b1;
        if (instr.opcode == opLoadLocal)
        begin
          localWe    = 1'b1;
          localAddr  = instr.imm[LocalIdxWidth-1:0];
          localWData = heapRData;
        end
        else
        begin
          emit = 1'b1;
          if (instr.opcode == opOutLocal)
          begin
            emitData = localRData;
          end
        end
      end
      default:
      begin
        stateNext = sIdle;
      end
    endcase
    if (advance)
    begin
      if (pcQ == PcWidth'(NProg - 1))
      begin
        stop = 1'b1;                                   // Ran off the end
      end
      else
      begin
        stateNext = sFetch;
        pc        = pcQ + 1'b1;
      end
    end
    if (stop)
    begin
      stateNext = sDone;
    end
  end

  // --------------------------------------------------------------------------
  // State, status and output
  // --------------------------------------------------------------------------
  always_ff @(posedge run or negedge rstN)
  begin
    if (!rstN)
    begin
      state    <= sIdle;
      pcQ      <= '0;
      finished <= 1'b0;
      fault    <= 1'b0;
      outValid <= 1'b0;
      seqCount <= '0;
    end
    else
    begin
      state    <= stateNext;
      pcQ      <= pc;
      outValid <= emit;
      if (clearAll)
      begin
        finished <= 1'b0;
        fault    <= 1'b0;
        seqCount <= '0;
      end
      else
      begin
        if (stop)
        begin
          finished <= 1'b1;                            // Both rise together
          fault    <= stopFault;
        end
        if (emit)
        begin
          seqCount <= seqCount + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge run)
  begin
    if (emit)
    begin
      outWord.data <= emitData;
      outWord.seq  <= seqCount;
    end
  end

endmodule

//--- verilog/stepTimer.sv
// Saturating count of executed instructions.
// limitHit stays high from the MaxSteps-th tick until clear.
`timescale 1ns/1ps

module stepTimer
  import arrayMachinePkg::*;
(
  input  logic run,
  input  logic rstN,
  input  logic clear,
  input  logic stepTick,
  output logic limitHit
);

  logic [StepWidth-1:0] count;

  assign limitHit = count == StepWidth'(MaxSteps);

  always_ff @(posedge run or negedge rstN)
  begin
    if (!rstN)
    begin
      count <= '0;
    end
    else if (clear)
    begin
      count <= '0;
    end
    else if (stepTick && !limitHit)
    begin
      count <= count + 1'b1;                           // Holds at the limit
    end
  end

endmodule
